/* hdl/frame_macros.svh */
// Shared frame constants
// Data widths, game reset hold time and board options

`ifndef FRAME_MACROS_SVH
`define FRAME_MACROS_SVH

`define FRAME_GAME_COLW         4   // Game colour component
`define FRAME_VGA_COLW          6   // VGA colour component
`define FRAME_SND_W             16  // Sound sample

// Cycles of game reset after the last cause
`define FRAME_RST_HOLD          16

`define FRAME_GAME_ACTIVE_HIGH  0   // 0 gives active-low game inputs
`define FRAME_THREE_BUTTONS     0   // 0 keeps button 3 released
`define FRAME_SIGNED_SND        0   // Two's complement samples when set

`endif

/* hdl/frame_video_pkg.sv */
// Video types for the frame
// Colour component typedefs, game pixel and VGA pixel structs

`include "frame_macros.svh"

package frame_video_pkg;

    typedef logic [`FRAME_GAME_COLW-1:0] game_col_t;
    typedef logic [`FRAME_VGA_COLW-1:0]  vga_col_t;

    // Pixel as the game core produces it
    typedef struct packed {
        game_col_t r;
        game_col_t g;
        game_col_t b;
        logic      lhbl;    // Active low
        logic      lvbl;    // Active low
        logic      hs;
        logic      vs;
    } game_pixel_t;

    // Pixel towards the VGA connector
    typedef struct packed {
        vga_col_t r;
        vga_col_t g;
        vga_col_t b;
        logic     hs;
        logic     vs;
    } vga_pixel_t;

endpackage

/* hdl/frame_ctrl_pkg.sv */
// Control types for the frame
// Board and game joystick structs, game input bundle, sound sample

`include "frame_macros.svh"

package frame_ctrl_pkg;

    // Controller word, all bits active high
    typedef struct packed {
        logic pause;
        logic start;
        logic coin;
        logic b3;
        logic b2;
        logic b1;
        logic up;
        logic down;
        logic left;
        logic right;
    } board_joy_t;

    typedef struct packed {
        logic b3;
        logic b2;
        logic b1;
        logic up;
        logic down;
        logic left;
        logic right;
    } game_joy_t;

    typedef struct packed {
        game_joy_t  joy1;
        game_joy_t  joy2;
        logic [1:0] coin;   // Player 2 in the MSB
        logic [1:0] start;
        logic       pause;
    } game_inputs_t;

    typedef logic [`FRAME_SND_W-1:0] snd_t;

endpackage

/* hdl/frame_reset.sv */
// Game reset generator
// Merges board reset, DIP flip changes, reset requests and ROM download
// and stretches the result with a hold counter

`include "frame_macros.svh"

module frame_reset (
    input  logic clk_sys,
    input  logic rst,
    input  logic dip_flip,
    input  logic rst_req,
    input  logic downloading,
    output logic game_rst
);

    localparam int CNT_W = $clog2(`FRAME_RST_HOLD + 1);
    localparam logic [CNT_W-1:0] HOLD = CNT_W'(`FRAME_RST_HOLD);

    logic             dip_last;
    logic             dip_change;
    logic             cause;
    logic [CNT_W-1:0] hold_cnt;

    assign dip_change = dip_flip != dip_last;

    // Board reset is handled in the register branch below
    assign cause = downloading | rst_req | dip_change;

    // Previous DIP flip setting
    always_ff @(posedge clk_sys) begin
        dip_last <= dip_flip;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hold_cnt <= HOLD;
            game_rst <= 1'b1;
        end else begin
            if (cause) begin
                hold_cnt <= HOLD;               // Restart the hold time
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
            // Sees the count before this edge's update
            game_rst <= hold_cnt != '0;
        end
    end

endmodule

/* hdl/frame_inputs.sv */
// Player input mapping
// Picks joystick fields for the game, masks button 3, toggles pause
// and applies the game input polarity on a registered output

`include "frame_macros.svh"

module frame_inputs (
    input  logic                         clk_sys,
    input  logic                         game_rst,
    input  frame_ctrl_pkg::board_joy_t   board_joy1,
    input  frame_ctrl_pkg::board_joy_t   board_joy2,
    output frame_ctrl_pkg::game_inputs_t game_in
);

    import frame_ctrl_pkg::*;

    localparam int   GI_W   = $bits(game_inputs_t);
    localparam logic INVERT = (`FRAME_GAME_ACTIVE_HIGH == 0);

    logic [1:0]   pause_last;
    logic         pause_st;
    logic         pause_nxt;
    game_inputs_t mapped;     // Active-high view of the outputs

    function automatic game_joy_t pick_joy(board_joy_t bj);
        game_joy_t gj;
        gj.b3    = (`FRAME_THREE_BUTTONS != 0) ? bj.b3 : 1'b0;
        gj.b2    = bj.b2;
        gj.b1    = bj.b1;
        gj.up    = bj.up;
        gj.down  = bj.down;
        gj.left  = bj.left;
        gj.right = bj.right;
        return gj;
    endfunction

    // Either player's pause press flips the state
    assign pause_nxt = pause_st ^ ((board_joy1.pause & ~pause_last[0]) |
                                   (board_joy2.pause & ~pause_last[1]));

    always_comb begin
        mapped.joy1  = pick_joy(board_joy1);
        mapped.joy2  = pick_joy(board_joy2);
        mapped.coin  = {board_joy2.coin, board_joy1.coin};
        mapped.start = {board_joy2.start, board_joy1.start};
        mapped.pause = pause_nxt;
    end

    // Tracked through game reset, so a held key gives no edge after it
    always_ff @(posedge clk_sys) begin
        pause_last <= {board_joy2.pause, board_joy1.pause};
    end

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            pause_st <= 1'b0;
            game_in  <= game_inputs_t'({GI_W{INVERT}});    // All inactive
        end else begin
            pause_st <= pause_nxt;
            game_in  <= game_inputs_t'(mapped ^ {GI_W{INVERT}});
        end
    end

endmodule

/* hdl/frame_video.sv */
// Video output stage
// Expands game colour to VGA width, applies blanking and the
// scanline effect, and registers the syncs with the colour

`include "frame_macros.svh"

module frame_video (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  logic                        pxl_cen,
    input  logic                        en_mixing,
    input  frame_video_pkg::game_pixel_t game_pix,
    output frame_video_pkg::vga_pixel_t  vga_pix
);

    import frame_video_pkg::*;

    localparam int EXT_W = `FRAME_VGA_COLW - `FRAME_GAME_COLW;

    logic hs_last;
    logic vs_last;
    logic line_odd;
    logic line_odd_nxt;
    logic blank;
    logic dim;

    // MSBs repeated into the new LSBs so full scale stays full scale
    function automatic vga_col_t expand(game_col_t c, logic blk, logic half);
        vga_col_t v;
        v = {c, c[`FRAME_GAME_COLW-1 -: EXT_W]};
        if (blk) begin
            v = '0;
        end else if (half) begin
            v = v >> 1;
        end
        return v;
    endfunction

    // Line parity, vertical sync wins over a coincident hsync edge
    always_comb begin
        line_odd_nxt = line_odd;
        if (game_pix.vs && !vs_last) begin
            line_odd_nxt = 1'b0;
        end else if (game_pix.hs && !hs_last) begin
            line_odd_nxt = ~line_odd;
        end
    end

    assign blank = ~(game_pix.lhbl & game_pix.lvbl);
    assign dim   = en_mixing & line_odd_nxt;        // Darken odd lines

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hs_last  <= 1'b0;
            vs_last  <= 1'b0;
            line_odd <= 1'b0;
            vga_pix  <= '0;
        end else if (pxl_cen) begin
            hs_last    <= game_pix.hs;
            vs_last    <= game_pix.vs;
            line_odd   <= line_odd_nxt;
            vga_pix.r  <= expand(game_pix.r, blank, dim);
            vga_pix.g  <= expand(game_pix.g, blank, dim);
            vga_pix.b  <= expand(game_pix.b, blank, dim);
            vga_pix.hs <= game_pix.hs;
            vga_pix.vs <= game_pix.vs;
        end
    end

endmodule

/* hdl/frame_sound_dac.sv */
// Sound DAC
// First-order sigma-delta modulator, 16-bit sample in, 1-bit PWM out

`include "frame_macros.svh"

module frame_sound_dac (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  frame_ctrl_pkg::snd_t snd,
    output logic                 audio
);

    import frame_ctrl_pkg::*;

    localparam int W = `FRAME_SND_W;

    snd_t       sample;     // Offset binary
    snd_t       acc;
    logic [W:0] sum;

    // Signed samples get their MSB flipped
    always_comb begin
        sample = snd;
        if (`FRAME_SIGNED_SND != 0) begin
            sample[W-1] = ~snd[W-1];
        end
    end

    assign sum = {1'b0, acc} + {1'b0, sample};

    // Carry density follows sample / 2^W
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            acc   <= '0;
            audio <= 1'b0;
        end else begin
            acc   <= sum[W-1:0];
            audio <= sum[W];
        end
    end

endmodule

/* hdl/frame_lite.sv */
// Reduced board frame for an arcade core
// Game reset, player inputs, VGA video and sigma-delta sound

module frame_lite (
    input  logic                          clk_sys,
    input  logic                          rst,          // Board reset
    input  logic                          pxl_cen,
    // Reset causes
    input  logic                          dip_flip,     // Any change restarts the game
    input  logic                          rst_req,
    input  logic                          downloading,
    // Controllers
    input  frame_ctrl_pkg::board_joy_t    board_joy1,
    input  frame_ctrl_pkg::board_joy_t    board_joy2,
    // Game video and sound
    input  frame_video_pkg::game_pixel_t  game_pix,
    input  logic                          en_mixing,
    input  frame_ctrl_pkg::snd_t          snd,
    // Towards the game
    output logic                          game_rst,
    output frame_ctrl_pkg::game_inputs_t  game_in,
    // Towards the board
    output frame_video_pkg::vga_pixel_t   vga_pix,
    output logic                          audio
);

    frame_reset u_reset (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .dip_flip    ( dip_flip    ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .game_rst    ( game_rst    )
    );

    // Inputs follow the game reset
    frame_inputs u_inputs (
        .clk_sys     ( clk_sys     ),
        .game_rst    ( game_rst    ),
        .board_joy1  ( board_joy1  ),
        .board_joy2  ( board_joy2  ),
        .game_in     ( game_in     )
    );

    // Video and sound keep running through a game reset
    frame_video u_video (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .en_mixing   ( en_mixing   ),
        .game_pix    ( game_pix    ),
        .vga_pix     ( vga_pix     )
    );

    frame_sound_dac u_dac (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .snd         ( snd         ),
        .audio       ( audio       )   // Same stream for both channels
    );

endmodule

/* sim/frame_lite_tb.sv */
// Testbench for the reduced arcade board frame
// Reads vectors from the stimulus file, drives the DUT and checks
// game reset, player inputs, video and sound, with a watchdog

module frame_lite_tb;

    import frame_ctrl_pkg::*;
    import frame_video_pkg::*;

    localparam int MAX_TESTS = 64;
    localparam int CLK_T     = 8;
    localparam     STIM_FILE = "sim/frame_stimulus.txt";

    logic         clk_sys;
    logic         rst;
    logic         pxl_cen;
    logic         dip_flip;
    logic         rst_req;
    logic         downloading;
    board_joy_t   board_joy1;
    board_joy_t   board_joy2;
    game_pixel_t  game_pix;
    logic         en_mixing;
    snd_t         snd;
    logic         game_rst;
    game_inputs_t game_in;
    vga_pixel_t   vga_pix;
    logic         audio;

    // Test table
    logic [8*16-1:0] t_name   [MAX_TESTS];
    logic [8*8-1:0]  t_kind   [MAX_TESTS];
    logic [31:0]     t_a0     [MAX_TESTS];
    logic [31:0]     t_a1     [MAX_TESTS];
    logic [31:0]     t_a2     [MAX_TESTS];
    int              t_cycles [MAX_TESTS];
    logic [31:0]     t_exp    [MAX_TESTS];
    int              n_tests;
    int              pass_cnt;
    int              fail_cnt;
    int              wd_cycles;

    frame_lite i_frame_lite (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .pxl_cen     ( pxl_cen     ),
        .dip_flip    ( dip_flip    ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .board_joy1  ( board_joy1  ),
        .board_joy2  ( board_joy2  ),
        .game_pix    ( game_pix    ),
        .en_mixing   ( en_mixing   ),
        .snd         ( snd         ),
        .game_rst    ( game_rst    ),
        .game_in     ( game_in     ),
        .vga_pix     ( vga_pix     ),
        .audio       ( audio       )
    );

    always #(CLK_T/2) clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        pxl_cen <= ~pxl_cen;    // Pixel strobe every other cycle
    end

    task automatic load_tests(output bit ok);
        int               fd;
        int               cnt;
        int               cyc;
        int               sum;
        logic [8*128-1:0] text;
        logic [8*16-1:0]  name;
        logic [8*8-1:0]   kind;
        logic [31:0]      a0;
        logic [31:0]      a1;
        logic [31:0]      a2;
        logic [31:0]      exp_v;
        sum = 0;
        fd = $fopen(STIM_FILE, "r");
        ok = fd != 0;
        if (!ok) begin
            $display("Cannot open %0s for reading", STIM_FILE);
        end else begin
            while (!$feof(fd)) begin
                text = '0;
                cnt = $fgets(text, fd);
                cnt = $sscanf(text, "%s %s %h %h %h %d %h", name, kind, a0, a1, a2, cyc, exp_v);
                // Comment and blank lines never give all seven fields
                if (cnt == 7 && n_tests < MAX_TESTS) begin
                    t_name[n_tests]   = name;
                    t_kind[n_tests]   = kind;
                    t_a0[n_tests]     = a0;
                    t_a1[n_tests]     = a1;
                    t_a2[n_tests]     = a2;
                    t_cycles[n_tests] = cyc;
                    t_exp[n_tests]    = exp_v;
                    sum += cyc;
                    n_tests++;
                end
            end
            $fclose(fd);
            ok = n_tests > 0;
            wd_cycles = sum * 2 + 200;
        end
    endtask

    task automatic check_value(input int i, input logic [31:0] act, inout bit ok);
        if (act !== t_exp[i]) begin
            $display("** Error: %0s expected %0h actual %0h", t_name[i], t_exp[i], act);
            ok = 1'b0;
        end
    endtask

    task automatic close_test(input int i, input bit ok);
        if (ok) begin
            pass_cnt++;
            $display("%0s: pass", t_name[i]);
        end else begin
            fail_cnt++;
            $display("%0s: FAIL", t_name[i]);
        end
    endtask

    task automatic wait_game_idle(input int limit, output bit idle);
        int n;
        n = 0;
        @(negedge clk_sys);
        while (game_rst !== 1'b0 && n < limit) begin
            @(negedge clk_sys);
            n++;
        end
        idle = game_rst === 1'b0;
    endtask

    // Edges from the last cause sample until game_rst reads low
    task automatic reset_hold(input int i);
        bit ok;
        bit done;
        int k;
        ok = 1'b1;
        done = 1'b0;
        k = 0;
        @(posedge clk_sys);
        case (t_a0[i])
            0: rst <= 1'b1;
            1: rst_req <= 1'b1;
            2: dip_flip <= ~dip_flip;
            default: downloading <= 1'b1;
        endcase
        repeat (t_a1[i]) @(posedge clk_sys);
        rst         <= 1'b0;    // This edge sampled the last cause
        rst_req     <= 1'b0;
        downloading <= 1'b0;
        while (!done && k < t_cycles[i]) begin
            @(posedge clk_sys);
            k++;
            @(negedge clk_sys);
            done = game_rst === 1'b0;
        end
        if (!done) begin
            $display("%0s: game reset still high after %0d cycles", t_name[i], k);
            ok = 1'b0;
        end else begin
            check_value(i, k, ok);
        end
        close_test(i, ok);
    endtask

    task automatic map_joysticks(input int i);
        bit ok;
        bit idle;
        ok = 1'b1;
        wait_game_idle(40, idle);
        if (!idle) begin
            $display("%0s: game reset never released", t_name[i]);
            ok = 1'b0;
        end else begin
            @(posedge clk_sys);
            board_joy1 <= t_a0[i][9:0];
            board_joy2 <= t_a1[i][9:0];
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_value(i, 32'(game_in), ok);
        end
        close_test(i, ok);
    endtask

    task automatic toggle_pause(input int i);
        bit ok;
        bit idle;
        bit held;
        int k;
        ok = 1'b1;
        idle = 1'b1;
        held = 1'b0;
        @(posedge clk_sys);
        if (t_a0[i] == 1) begin
            board_joy1.pause <= 1'b1;
        end else if (t_a0[i] == 2) begin
            board_joy2.pause <= 1'b1;
        end
        if (t_a1[i] == 0) begin
            board_joy1.pause <= 1'b0;
            board_joy2.pause <= 1'b0;
        end
        // Pause output must stay put while the key stays down
        for (k = 1; k <= t_a1[i]; k++) begin
            @(posedge clk_sys);
            if (k == t_a1[i]) begin
                board_joy1.pause <= 1'b0;       // Last edge that sees the press
                board_joy2.pause <= 1'b0;
            end
            @(negedge clk_sys);
            if (k == 1) begin
                held = game_in.pause;
            end else if (game_in.pause !== held) begin
                $display("%0s: pause changed again while the key was held", t_name[i]);
                ok = 1'b0;
            end
        end
        if (t_a2[i] != 0) begin
            @(posedge clk_sys);
            rst_req <= 1'b1;
            @(posedge clk_sys);
            rst_req <= 1'b0;
            @(posedge clk_sys);                 // game_rst is up after this edge
            wait_game_idle(t_cycles[i], idle);
        end
        if (!idle) begin
            $display("%0s: game reset never released after the request", t_name[i]);
            ok = 1'b0;
        end else begin
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_value(i, 32'(game_in.pause), ok);
        end
        close_test(i, ok);
    endtask

    task automatic pixel_sample(input int i);
        bit ok;
        ok = 1'b1;
        @(posedge clk_sys);
        // Old strobe value, so a high one means the next edge has none
        if (pxl_cen) begin
            @(posedge clk_sys);
        end
        game_pix  <= t_a0[i][15:0];
        en_mixing <= t_a1[i][0];
        @(posedge clk_sys);                     // Strobed sample
        @(negedge clk_sys);
        check_value(i, 32'(vga_pix), ok);
        close_test(i, ok);
    endtask

    task automatic audio_density(input int i);
        bit ok;
        int ones;
        ok = 1'b1;
        ones = 0;
        @(posedge clk_sys);
        snd <= t_a0[i][15:0];
        rst <= 1'b1;
        repeat (2) @(posedge clk_sys);
        rst <= 1'b0;
        repeat (t_cycles[i]) begin
            @(posedge clk_sys);
            @(negedge clk_sys);
            if (audio === 1'b1) begin
                ones++;
            end
        end
        check_value(i, ones, ok);
        close_test(i, ok);
    endtask

    initial begin
        wait (wd_cycles > 0);
        #(wd_cycles * CLK_T);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        bit loaded;
        bit idle;
        int i;
        clk_sys     = 1'b0;
        rst         = 1'b1;
        pxl_cen     = 1'b0;
        dip_flip    = 1'b0;
        rst_req     = 1'b0;
        downloading = 1'b0;
        board_joy1  = '0;
        board_joy2  = '0;
        game_pix    = '0;
        en_mixing   = 1'b0;
        snd         = '0;
        n_tests     = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        wd_cycles   = 0;
        load_tests(loaded);
        repeat (2) @(posedge clk_sys);
        rst <= 1'b0;
        if (!loaded) begin
            $display("Stimulus file missing or empty, no tests run");
            $display("Some tests failed");
            $finish;
        end else begin
            wait_game_idle(40, idle);
            if (!idle) begin
                $display("Game reset did not release after the board reset");
                fail_cnt++;
            end
            for (i = 0; i < n_tests; i++) begin
                case (t_kind[i])
                    "reset": reset_hold(i);
                    "input": map_joysticks(i);
                    "pause": toggle_pause(i);
                    "video": pixel_sample(i);
                    "sound": audio_density(i);
                    default: begin
                        $display("%0s: unknown test kind %0s", t_name[i], t_kind[i]);
                        fail_cnt++;
                    end
                endcase
            end
            $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
            $finish;
        end
    end

endmodule

/* files.f */
+incdir+hdl
hdl/frame_video_pkg.sv
hdl/frame_ctrl_pkg.sv
hdl/frame_reset.sv
hdl/frame_inputs.sv
hdl/frame_video.sv
hdl/frame_sound_dac.sv
hdl/frame_lite.sv
sim/frame_lite_tb.sv

/* sim/frame_stimulus.txt */
# columns: name kind arg0 arg1 arg2 cycles expected
# values: hex except cycles, which is decimal
# reset: source 0 rst 1 rst_req 2 dip_flip 3 downloading, cycles held, edges until release
rst_board     reset  0     2  0  40    11
rst_req       reset  1     1  0  40    11
rst_dip       reset  2     1  0  40    11
rst_download  reset  3     6  0  40    11
# input: joy1 and joy2 words, expected game_in
map_idle      input  000   000  0  4   7ffff
map_right     input  001   000  0  4   7efff
map_buttons   input  07f   000  0  4   40fff
map_coin      input  180   100  0  4   7fff1
map_p2        input  000   0aa  0  4   7faaf
map_b3        input  040   040  0  4   7ffff
# pause: player, cycles the bit is held, rst_req afterwards, expected pause output
pause_p1      pause  1     1  0  30    0
pause_p2      pause  2     1  0  30    1
pause_hold    pause  1     5  0  30    0
pause_clear   pause  0     0  1  30    1
# video: game_pix and en_mixing, expected vga_pix
vid_vs        video  f81d  0  0  4     fe211
vid_hblank    video  a5c4  0  0  4     00000
vid_vblank    video  73ea  0  0  4     00002
vid_expand    video  5a3c  0  0  4     56a30
scan_odd      video  fffc  1  0  4     7df7c
scan_even     video  fffe  1  0  4     ffffe
scan_low      video  842c  1  0  4     89120
scan_odd2     video  842e  1  0  4     44812
scan_vs       video  842d  1  0  4     89121
# sound: sample, expected ones over the window
snd_zero      sound  0000  0  0  1024  000
snd_quarter   sound  4000  0  0  1024  100
snd_half      sound  8000  0  0  1024  200
snd_3q        sound  c000  0  0  1024  300
snd_odd       sound  1234  0  0  1024  048
snd_full      sound  ffff  0  0  1024  3ff
